//--- alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// datapath width in bits
`define ALU_W 8

// largest legal digit in a BCD nibble
`define BCD_MAX_DIGIT 9

`endif

//--- alu_pkg.sv
`default_nettype none
`include "alu_cfg.svh"

package alu_pkg;

    typedef logic [`ALU_W-1:0] data_t;       // one datapath byte
    typedef logic [3:0]        nibble_t;     // one bcd digit

    typedef enum logic [3:0] {
        OP_ADC = 4'h0,
        OP_SBC = 4'h1,
        OP_AND = 4'h2,
        OP_EOR = 4'h3,
        OP_ORA = 4'h4,
        OP_LSR = 4'h5,
        OP_ROR = 4'h6,
        OP_LDA = 4'h7,
        OP_LDX = 4'h8,
        OP_CLC = 4'h9,
        OP_SEC = 4'ha,
        OP_CLD = 4'hb,
        OP_SED = 4'hc
    } alu_op_e;

    // load and function strobes seen by the alu
    typedef struct packed {
        logic ldb_inv_db;                    // ~db on b
        logic ldb_db;                        // db on b
        logic ldb_adl;                       // adl (x) on b
        logic lda_sb;                        // sb (acc) on a
        logic lda_zero;                      // zero on a
        logic enable_dec;
        logic carry_in;
        logic e_sum;
        logic e_and;
        logic e_eor;
        logic e_or;
        logic e_shiftr;
    } alu_ctrl_t;

    typedef struct packed {
        data_t result;
        logic  carry_out;
        logic  overflow;
    } alu_res_t;

    typedef struct packed {
        logic n;
        logic v;
        logic d;
        logic z;
        logic c;
    } flags_t;

    typedef struct packed {
        logic upd_nz;
        logic upd_c;
        logic upd_v;
        logic set_c;
        logic clr_c;
        logic set_d;
        logic clr_d;
    } flag_upd_t;

endpackage

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_cfg.svh"

module alu
    import alu_pkg::*;
(
    input  data_t     db_bus,
    input  data_t     adl_bus,
    input  data_t     sb_bus,
    input  alu_ctrl_t ctrl,
    output alu_res_t  res
);

    data_t   a;
    data_t   b;
    data_t   b_dec;                          // b as the operand before inversion
    data_t   sum;
    logic    sum_carry;
    logic    lo_carry;
    logic    hi_carry;
    nibble_t lo_dig;
    nibble_t hi_dig;
    logic    in_bcd;

    // one digit of decimal adjust, returns {carry, digit}
    // subtraction works on the inverted operand, so carry set means no borrow
    function automatic logic [4:0] bcd_fix(input logic [4:0] raw, input logic sub);
        logic    dc;
        nibble_t dig;
        if (sub) begin
            dc  = raw[4];
            dig = dc ? raw[3:0] : raw[3:0] + nibble_t'(`BCD_MAX_DIGIT + 1);
        end else begin
            dc  = raw > 5'(`BCD_MAX_DIGIT);
            dig = dc ? raw[3:0] + nibble_t'(15 - `BCD_MAX_DIGIT) : raw[3:0];
        end
        return {dc, dig};
    endfunction

    assign b = ctrl.ldb_inv_db ? ~db_bus :
               ctrl.ldb_db     ? db_bus  :
               ctrl.ldb_adl    ? adl_bus : '0;
    assign a = (ctrl.lda_sb && !ctrl.lda_zero) ? sb_bus : '0;   // zero wins

    assign {sum_carry, sum} = {1'b0, a} + {1'b0, b} + (`ALU_W+1)'(ctrl.carry_in);

    // low digit carry feeds the high digit
    assign {lo_carry, lo_dig} = bcd_fix({1'b0, a[3:0]} + {1'b0, b[3:0]}
                                        + 5'(ctrl.carry_in), ctrl.ldb_inv_db);
    assign {hi_carry, hi_dig} = bcd_fix({1'b0, a[7:4]} + {1'b0, b[7:4]}
                                        + 5'(lo_carry), ctrl.ldb_inv_db);

    always_comb begin
        res = '0;
        if (ctrl.e_sum) begin
            if (ctrl.enable_dec) begin
                res.result    = {hi_dig, lo_dig};
                res.carry_out = hi_carry;
            end else begin
                res.result    = sum;
                res.carry_out = sum_carry;
            end
            // same input signs, different result sign
            res.overflow = (a[`ALU_W-1] == b[`ALU_W-1]) && (sum[`ALU_W-1] != a[`ALU_W-1]);
        end
        if (ctrl.e_and) begin
            res.result = a & b;
        end
        if (ctrl.e_eor) begin
            res.result = a ^ b;
        end
        if (ctrl.e_or) begin
            res.result = a | b;
        end
        if (ctrl.e_shiftr) begin
            res.result    = {ctrl.carry_in, a[`ALU_W-1:1]};   // carry_in 0 for lsr
            res.carry_out = a[0];
        end
    end

    assign b_dec  = ctrl.ldb_inv_db ? ~b : b;
    assign in_bcd = (a[3:0] <= nibble_t'(`BCD_MAX_DIGIT)) && (a[7:4] <= nibble_t'(`BCD_MAX_DIGIT))
                 && (b_dec[3:0] <= nibble_t'(`BCD_MAX_DIGIT))
                 && (b_dec[7:4] <= nibble_t'(`BCD_MAX_DIGIT));

    // valid bcd in must give valid bcd out, for add and subtract alike
    always_comb begin
        if (ctrl.e_sum && ctrl.enable_dec && in_bcd) begin
            assert ((lo_dig <= nibble_t'(`BCD_MAX_DIGIT)) && (hi_dig <= nibble_t'(`BCD_MAX_DIGIT)))
                else $error("alu: decimal result %h is not bcd", {hi_dig, lo_dig});
        end
    end

endmodule

`default_nettype wire

//--- alu_ctrl_decode.sv
`timescale 1ns/1ns
`default_nettype none

module alu_ctrl_decode
    import alu_pkg::*;
(
    input  alu_op_e   op,
    input  logic      op_valid,
    input  logic      use_x,
    input  flags_t    flags,
    output alu_ctrl_t ctrl,
    output flag_upd_t upd,
    output logic      acc_we,
    output logic      x_we
);

    // sbc always takes the inverted data bus, use_x has no effect on it
    always_comb begin
        ctrl   = '0;
        upd    = '0;
        acc_we = 1'b0;
        x_we   = 1'b0;
        if (op_valid) begin
            case (op)
                OP_ADC, OP_SBC: begin
                    ctrl.ldb_inv_db = (op == OP_SBC);
                    ctrl.ldb_db     = (op == OP_ADC) && !use_x;
                    ctrl.ldb_adl    = (op == OP_ADC) && use_x;
                    ctrl.lda_sb     = 1'b1;
                    ctrl.e_sum      = 1'b1;
                    ctrl.carry_in   = flags.c;
                    ctrl.enable_dec = flags.d;
                    acc_we          = 1'b1;
                    upd.upd_nz      = 1'b1;
                    upd.upd_c       = 1'b1;
                    upd.upd_v       = !flags.d;          // v kept in decimal mode
                end
                OP_AND, OP_EOR, OP_ORA: begin
                    ctrl.ldb_db  = !use_x;
                    ctrl.ldb_adl = use_x;
                    ctrl.lda_sb  = 1'b1;
                    ctrl.e_and   = (op == OP_AND);
                    ctrl.e_eor   = (op == OP_EOR);
                    ctrl.e_or    = (op == OP_ORA);
                    acc_we       = 1'b1;
                    upd.upd_nz   = 1'b1;
                end
                OP_LSR, OP_ROR: begin
                    ctrl.ldb_db   = 1'b1;                // b unused, kept one-hot
                    ctrl.lda_sb   = 1'b1;
                    ctrl.e_shiftr = 1'b1;
                    ctrl.carry_in = (op == OP_ROR) && flags.c;
                    acc_we        = 1'b1;
                    upd.upd_nz    = 1'b1;
                    upd.upd_c     = 1'b1;
                end
                OP_LDA, OP_LDX: begin
                    ctrl.ldb_db   = !use_x;
                    ctrl.ldb_adl  = use_x;
                    ctrl.lda_zero = 1'b1;                // 0 | b passes b
                    ctrl.e_or     = 1'b1;
                    acc_we        = (op == OP_LDA);
                    x_we          = (op == OP_LDX);
                    upd.upd_nz    = 1'b1;
                end
                OP_CLC: upd.clr_c = 1'b1;
                OP_SEC: upd.set_c = 1'b1;
                OP_CLD: upd.clr_d = 1'b1;
                OP_SED: upd.set_d = 1'b1;
                default: ;
            endcase
        end
    end

    always_comb begin
        assert ($onehot0({ctrl.e_sum, ctrl.e_and, ctrl.e_eor, ctrl.e_or, ctrl.e_shiftr})
                && $onehot0({ctrl.ldb_inv_db, ctrl.ldb_db, ctrl.ldb_adl}))
            else $error("alu_ctrl_decode: strobe conflict for op %s", op.name());
    end

endmodule

`default_nettype wire

//--- status_reg.sv
`timescale 1ns/1ns
`default_nettype none

module status_reg
    import alu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  flag_upd_t upd,
    input  alu_res_t  res,
    output flags_t    flags
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            if (upd.upd_nz) begin
                flags.n <= res.result[$bits(data_t)-1];
                flags.z <= (res.result == '0);
            end
            if (upd.upd_c) begin
                flags.c <= res.carry_out;
            end else if (upd.set_c) begin
                flags.c <= 1'b1;
            end else if (upd.clr_c) begin
                flags.c <= 1'b0;
            end
            if (upd.upd_v) begin
                flags.v <= res.overflow;
            end
            if (upd.set_d) begin                         // decimal mode on
                flags.d <= 1'b1;
            end else if (upd.clr_d) begin
                flags.d <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  data_t    operand,
    input  logic     acc_we,
    input  logic     x_we,
    input  alu_res_t res,
    output data_t    db_bus,
    output data_t    adl_bus,
    output data_t    sb_bus,
    output data_t    acc,
    output data_t    x_reg
);

    assign db_bus  = operand;                        // external data bus
    assign adl_bus = x_reg;
    assign sb_bus  = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (acc_we) begin
            acc <= res.result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_reg <= '0;
        end else if (x_we) begin
            x_reg <= res.result;
        end
    end

    // one destination per operation
    a_single_dest: assert property (@(posedge clk) disable iff (!rst_n) !(acc_we && x_we))
        else $error("reg_file: acc and x written in the same cycle");

endmodule

`default_nettype wire

//--- exec_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit_top
    import alu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    op_valid,
    input  alu_op_e op,
    input  logic    use_x,
    input  data_t   operand,
    output logic    done,
    output data_t   acc,
    output data_t   x_reg,
    output flags_t  flags
);

    alu_ctrl_t ctrl;
    flag_upd_t upd;
    alu_res_t  res;
    logic      acc_we;
    logic      x_we;
    data_t     db_bus;
    data_t     adl_bus;
    data_t     sb_bus;

    alu_ctrl_decode u_decode (.op(op), .op_valid(op_valid), .use_x(use_x), .flags(flags),
                              .ctrl(ctrl), .upd(upd), .acc_we(acc_we), .x_we(x_we));

    reg_file u_regs (.clk(clk), .rst_n(rst_n), .operand(operand), .acc_we(acc_we),
                     .x_we(x_we), .res(res), .db_bus(db_bus), .adl_bus(adl_bus),
                     .sb_bus(sb_bus), .acc(acc), .x_reg(x_reg));

    alu u_alu (.db_bus(db_bus), .adl_bus(adl_bus), .sb_bus(sb_bus), .ctrl(ctrl), .res(res));

    status_reg u_status (.clk(clk), .rst_n(rst_n), .upd(upd), .res(res), .flags(flags));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= op_valid;                        // results visible with done
        end
    end

    // flag ops must not touch the data registers
    a_flag_op_regs: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid && (op inside {OP_CLC, OP_SEC, OP_CLD, OP_SED})
        |=> $stable(acc) && $stable(x_reg))
        else $error("exec_unit_top: flag op changed a data register");

    // decimal add and subtract keep v
    a_dec_keeps_v: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid && flags.d && (op inside {OP_ADC, OP_SBC}) |=> $stable(flags.v))
        else $error("exec_unit_top: v changed by a decimal op");

endmodule

`default_nettype wire

//--- tb_exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exec_unit
    import alu_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        op_valid;
    alu_op_e     op;
    logic        use_x;
    data_t       operand;
    logic        done;
    data_t       acc;
    data_t       x_reg;
    flags_t      flags;

    logic [31:0] lfsr = 32'h2f6d_5bde;
    data_t       exp_acc;
    data_t       exp_x;
    flags_t      exp_flags;
    logic        exp_done;

    exec_unit_top UUT (.clk(clk), .rst_n(rst_n), .op_valid(op_valid), .op(op), .use_x(use_x),
                       .operand(operand), .done(done), .acc(acc), .x_reg(x_reg), .flags(flags));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic data_t rand_bcd();
        return {nibble_t'(rand_bits(4) % 10), nibble_t'(rand_bits(4) % 10)};
    endfunction

    function automatic int dec_val(input data_t v);
        return int'(v[7:4]) * 10 + int'(v[3:0]);
    endfunction

    function automatic data_t to_bcd(input int v);
        return {nibble_t'(v / 10), nibble_t'(v % 10)};
    endfunction

    task automatic report_failure();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] expv,
                                 input logic [31:0] got);
        $display("[FAIL] %s expected %0h got %0h", name, expv, got);
        report_failure();
    endtask

    task automatic drive_op(input alu_op_e o, input data_t val, input logic sel_x);
        @(posedge clk);
        op_valid <= 1'b1;
        op       <= o;
        operand  <= val;
        use_x    <= sel_x;
    endtask

    // single op, then wait for its done pulse
    task automatic run_op(input alu_op_e o, input data_t val, input logic sel_x);
        int waited;
        waited = 0;
        drive_op(o, val, sel_x);
        @(posedge clk);
        op_valid <= 1'b0;
        @(negedge clk);
        while (!done && waited < 8) begin
            waited++;
            @(negedge clk);
        end
        if (!done) begin
            $display("timeout: no done pulse after %s", o.name());
            report_failure();
        end
    endtask

    always @(posedge clk or negedge rst_n) begin : ref_model
        data_t  b;
        data_t  r;
        flags_t f;
        int     s;
        int     ci;
        if (!rst_n) begin
            exp_acc   <= '0;
            exp_x     <= '0;
            exp_flags <= '0;
            exp_done  <= 1'b0;
        end else begin
            exp_done <= op_valid;
            if (op_valid) begin
                b  = (use_x && op != OP_SBC) ? exp_x : operand;   // sbc always reads the bus
                r  = b;
                f  = exp_flags;
                ci = int'(f.c);
                case (op)
                    OP_ADC, OP_SBC: begin
                        if (f.d) begin
                            s   = (op == OP_ADC) ? dec_val(exp_acc) + dec_val(b) + ci
                                                 : dec_val(exp_acc) - dec_val(b) - (1 - ci);
                            f.c = (op == OP_ADC) ? (s >= 100) : (s >= 0);
                            r   = to_bcd((s + 100) % 100);
                        end else begin
                            s   = (op == OP_ADC) ? int'(exp_acc) + int'(b) + ci
                                                 : int'(exp_acc) - int'(b) - (1 - ci);
                            f.c = (op == OP_ADC) ? (s > 255) : (s >= 0);
                            r   = s[7:0];
                            s   = (op == OP_ADC) ? int'($signed(exp_acc)) + int'($signed(b)) + ci
                                                 : int'($signed(exp_acc)) - int'($signed(b)) - (1 - ci);
                            f.v = (s > 127) || (s < -128);
                        end
                    end
                    OP_AND: r = exp_acc & b;
                    OP_EOR: r = exp_acc ^ b;
                    OP_ORA: r = exp_acc | b;
                    OP_LSR, OP_ROR: begin
                        r   = {(op == OP_ROR) && f.c, exp_acc[7:1]};
                        f.c = exp_acc[0];
                    end
                    OP_CLC: f.c = 1'b0;
                    OP_SEC: f.c = 1'b1;
                    OP_CLD: f.d = 1'b0;
                    OP_SED: f.d = 1'b1;
                    default: ;                                   // lda and ldx pass b
                endcase
                if (!(op inside {OP_CLC, OP_SEC, OP_CLD, OP_SED})) begin
                    f.n = r[7];
                    f.z = (r == '0);
                    if (op == OP_LDX) begin
                        exp_x <= r;
                    end else begin
                        exp_acc <= r;
                    end
                end
                exp_flags <= f;
            end
        end
    end

    a_done: assert property (@(posedge clk) disable iff (!rst_n) done == exp_done)
        else show_mismatch("done", 32'($sampled(exp_done)), 32'($sampled(done)));
    a_acc: assert property (@(posedge clk) disable iff (!rst_n) acc == exp_acc)
        else show_mismatch("acc", 32'($sampled(exp_acc)), 32'($sampled(acc)));
    a_x_reg: assert property (@(posedge clk) disable iff (!rst_n) x_reg == exp_x)
        else show_mismatch("x_reg", 32'($sampled(exp_x)), 32'($sampled(x_reg)));
    a_flags: assert property (@(posedge clk) disable iff (!rst_n) flags == exp_flags)
        else show_mismatch("flags", 32'($sampled(exp_flags)), 32'($sampled(flags)));

    initial begin
        alu_op_e burst_op;
        rst_n    = 1'b0;
        op_valid = 1'b0;
        op       = OP_LDA;
        use_x    = 1'b0;
        operand  = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 40; i++) begin                   // binary adc and sbc
            run_op(OP_LDX, data_t'(rand_bits(8)), 1'b0);
            run_op(OP_LDA, data_t'(rand_bits(8)), 1'b0);
            run_op((rand_bits(1) != 0) ? OP_SEC : OP_CLC, '0, 1'b0);
            if (rand_bits(1) != 0) begin
                run_op(OP_SBC, data_t'(rand_bits(8)), 1'b0);
            end else begin
                run_op(OP_ADC, data_t'(rand_bits(8)), rand_bits(1) != 0);
            end
        end
        for (int i = 0; i < 40; i++) begin                   // logic ops and shifts
            run_op(OP_LDA, data_t'(rand_bits(8)), 1'b0);
            run_op((rand_bits(1) != 0) ? OP_SEC : OP_CLC, '0, 1'b0);
            run_op(alu_op_e'(4'(2 + rand_bits(3) % 5)), data_t'(rand_bits(8)), rand_bits(1) != 0);
        end
        run_op(OP_SED, '0, 1'b0);
        for (int i = 0; i < 30; i++) begin                   // decimal mode
            run_op(OP_LDA, rand_bcd(), 1'b0);
            run_op((rand_bits(1) != 0) ? OP_SEC : OP_CLC, '0, 1'b0);
            run_op((rand_bits(1) != 0) ? OP_SBC : OP_ADC, rand_bcd(), 1'b0);
        end
        run_op(OP_CLD, '0, 1'b0);
        run_op(OP_ADC, 8'h99, 1'b0);                         // binary again
        for (int i = 0; i < 24; i++) begin                   // back-to-back, d stays clear
            burst_op = alu_op_e'(4'(rand_bits(4) % 11));
            drive_op(burst_op, data_t'(rand_bits(8)), (burst_op != OP_SBC) && (rand_bits(1) != 0));
        end
        run_op(OP_LDA, 8'h00, 1'b0);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
alu_pkg.sv
alu.sv
alu_ctrl_decode.sv
status_reg.sv
reg_file.sv
exec_unit_top.sv
tb_exec_unit.sv

//--- run.sh
#!/bin/sh
# compile and run the exec unit testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -f build.f --top-module tb_exec_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_exec_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^Result: PASSED$'; then
    exit 0
fi
exit 1
